//--- source/cmt_pkg.sv
// Commit stage shared definitions
package cmt_pkg;

   localparam int CW            = 4;   // Commit lanes per cycle
   localparam int P_CW          = 2;   // log2 of CW
   localparam int PC_W          = 30;  // Word-address program counter
   localparam int DW            = 32;
   localparam int PRF_AW        = 6;   // Physical register address
   localparam int LSU_IOPW      = 4;
   localparam int EPU_IOPW      = 6;
   localparam int BPU_UPD_W     = 32;  // Predictor update record
   localparam int BPU_TAKEN_BIT = 31;  // Predicted taken flag
   localparam int BPU_TGT_LSB   = 0;   // Predicted target of PC_W bits

   // One bit per commit lane
   typedef logic [CW-1:0]        lane_mask_t;

   // Count of 0 to CW lanes
   typedef logic [P_CW:0]        pop_size_t;

   typedef logic [PC_W-1:0]      pc_t;
   typedef logic [DW-1:0]        data_t;
   typedef logic [PRF_AW-1:0]    prf_addr_t;
   typedef logic [LSU_IOPW-1:0]  lsu_opc_t;    // Zero means no load/store
   typedef logic [EPU_IOPW-1:0]  epu_opc_t;    // Zero means no EPU operation
   typedef logic [BPU_UPD_W-1:0] bpu_upd_t;

   // One-hot lane-0 unit sequencer
   typedef enum logic [1:0]
   {
      FU_IDLE    = 2'b01,
      FU_PENDING = 2'b10
   } fu_state_e;

endpackage

//--- source/cmt_lane_sel.sv
// Commit lane selection
module cmt_lane_sel
   import cmt_pkg::*;
(
   input  lane_mask_t          cmt_valid,
   input  lsu_opc_t [CW-1:0]   cmt_lsu_opc,
   input  epu_opc_t [CW-1:0]   cmt_epu_opc,
   input  lane_mask_t          cmt_exc,
   input  lane_mask_t          cmt_fls,
   input  lane_mask_t          cmt_is_bcc,
   input  lane_mask_t          cmt_is_brel,
   input  lane_mask_t          cmt_is_breg,
   input  logic                se_fls,
   input  logic                flush,
   input  logic                cmt_ce,
   output logic                pipe_req,
   output logic                lsu_req0,
   output logic                epu_req0,
   output lane_mask_t          cmt_fire,
   output pop_size_t           cmt_pop_size
);
   lane_mask_t lsu_need;
   lane_mask_t epu_need;
   lane_mask_t is_br;
   lane_mask_t single;
   lane_mask_t cmt_mask;

   always_comb
      begin
         for (int i = 0; i < CW; i++)
            begin
               lsu_need[i] = ~se_fls & (|cmt_lsu_opc[i]);                // Squashed lanes ask nothing
               epu_need[i] = ~se_fls & ((|cmt_epu_opc[i]) | cmt_exc[i]);
               is_br[i]    = cmt_is_bcc[i] | cmt_is_breg[i] | cmt_is_brel[i];
            end
      end

   assign single = lsu_need | epu_need | cmt_fls | is_br;

   assign lsu_req0 = lsu_need[0];
   assign epu_req0 = epu_need[0];
   assign pipe_req = cmt_valid[0] & (lsu_need[0] | epu_need[0]);

   // A single-issue lane may only commit in lane 0, and it stops the lanes behind it
   always_comb
      begin
         logic run;
         run = cmt_ce & ~flush;
         cmt_mask[0] = run;
         run = run & ~single[0];
         for (int j = 1; j < CW; j++)
            begin
               run = run & ~single[j];
               cmt_mask[j] = run;
            end
      end

   assign cmt_fire = cmt_valid & cmt_mask;

   always_comb
      begin
         pop_size_t cnt;
         cnt = '0;
         for (int k = 0; k < CW; k++)
            cnt = cnt + pop_size_t'(cmt_fire[k]);
         cmt_pop_size = cnt;                                             // Lanes popped from ROB
      end

endmodule

//--- source/cmt_fu_seq.sv
// Lane-0 functional unit sequencer
module cmt_fu_seq
   import cmt_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       pipe_req,
   input  logic       lsu_req0,
   input  logic       epu_req0,
   input  logic       flush,
   input  logic       lsu_wb_valid,
   input  data_t      lsu_wb_dout,
   input  logic       epu_wb_valid,
   input  data_t      epu_wb_dout,
   input  logic       epu_wb_dout_sel,
   input  prf_addr_t  cmt_prd0,
   input  logic       cmt_prd_we0,
   output logic       cmt_ce,
   output logic       lsu_req_valid,
   output logic       epu_req_valid,
   output logic       prf_we,
   output prf_addr_t  prf_waddr,
   output data_t      prf_wdata
);
   fu_state_e state_ff;
   fu_state_e state_nxt;
   logic      pipe_finish;
   logic      req_issue;

   assign pipe_finish = lsu_wb_valid | epu_wb_valid;               // Done strobe from either unit
   assign req_issue   = (state_ff == FU_IDLE) & pipe_req;

   always_comb
      begin
         state_nxt = state_ff;
         case (state_ff)
            FU_IDLE:
               if (pipe_req)
                  state_nxt = FU_PENDING;
            FU_PENDING:
               if (pipe_finish)
                  state_nxt = FU_IDLE;
            default:
               state_nxt = FU_IDLE;
         endcase
      end

   always_ff @(posedge clk)
      begin
         if (!rst_n)
            state_ff <= FU_IDLE;
         else
            state_ff <= state_nxt;
      end

   // One request per operation; load/store wins if a lane claims both units
   assign lsu_req_valid = req_issue & lsu_req0;
   assign epu_req_valid = req_issue & epu_req0 & ~lsu_req0;

   // Hold commit until the unit reports done
   assign cmt_ce = ~pipe_req | pipe_finish;

   assign prf_we    = pipe_finish & ~flush & cmt_prd_we0;
   assign prf_waddr = cmt_prd0;
   assign prf_wdata = epu_wb_dout_sel ? epu_wb_dout : lsu_wb_dout;

endmodule

//--- source/cmt_redirect.sv
// Flush and predictor update
module cmt_redirect
   import cmt_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  lane_mask_t  cmt_fire,
   input  logic        cmt_fls0,
   input  logic        refetch,
   input  pc_t         cmt_pc0,
   input  data_t       cmt_opera0,
   input  logic        exc_flush,
   input  pc_t         exc_flush_tgt,
   input  logic        cmt_is_bcc0,
   input  logic        cmt_is_breg0,
   input  logic        cmt_is_brel0,
   input  bpu_upd_t    cmt_bpu_upd0,
   output logic        se_fls,
   output logic        flush,
   output pc_t         flush_tgt,
   output logic        bpu_wb,
   output logic        bpu_wb_is_bcc,
   output logic        bpu_wb_is_breg,
   output logic        bpu_wb_is_brel,
   output logic        bpu_wb_taken,
   output pc_t         bpu_wb_pc,
   output pc_t         bpu_wb_npc_act,
   output bpu_upd_t    bpu_wb_upd
);
   pc_t  npc0;
   pc_t  se_tgt_nxt;
   pc_t  se_tgt;
   logic is_br0;

   assign npc0       = cmt_pc0 + pc_t'(1);
   assign se_tgt_nxt = cmt_fls0 ? cmt_opera0[PC_W-1:0] : npc0;   // Mispredict or refetch

   // Pulses for one cycle since its own flush blocks lane 0 from firing again
   always_ff @(posedge clk)
      begin
         if (!rst_n)
            se_fls <= 1'b0;
         else
            se_fls <= cmt_fire[0] & (cmt_fls0 | refetch);
      end

   always_ff @(posedge clk)
      begin
         if (cmt_fire[0])
            se_tgt <= se_tgt_nxt;
      end

   // Speculative flush outranks the exception flush
   assign flush     = se_fls | exc_flush;
   assign flush_tgt = se_fls ? se_tgt : exc_flush_tgt;

   assign is_br0         = cmt_is_bcc0 | cmt_is_breg0 | cmt_is_brel0;
   assign bpu_wb         = cmt_fire[0] & is_br0;
   assign bpu_wb_is_bcc  = cmt_is_bcc0;
   assign bpu_wb_is_breg = cmt_is_breg0;
   assign bpu_wb_is_brel = cmt_is_brel0;
   assign bpu_wb_taken   = cmt_bpu_upd0[BPU_TAKEN_BIT] ^ cmt_fls0;  // Mispredict flips it
   assign bpu_wb_pc      = cmt_pc0;
   assign bpu_wb_npc_act = cmt_fls0 ? cmt_opera0[PC_W-1:0]
                                    : cmt_bpu_upd0[BPU_TGT_LSB +: PC_W];
   assign bpu_wb_upd     = cmt_bpu_upd0;

endmodule

//--- source/cmt.sv
// Commit stage top
module cmt
   import cmt_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   // From ROB
   input  lane_mask_t          cmt_valid,
   input  lsu_opc_t [CW-1:0]   cmt_lsu_opc,
   input  epu_opc_t [CW-1:0]   cmt_epu_opc,
   input  lane_mask_t          cmt_exc,
   input  lane_mask_t          cmt_fls,
   input  lane_mask_t          cmt_is_bcc,
   input  lane_mask_t          cmt_is_brel,
   input  lane_mask_t          cmt_is_breg,
   input  pc_t [CW-1:0]        cmt_pc,
   input  data_t [CW-1:0]      cmt_opera,
   input  prf_addr_t [CW-1:0]  cmt_prd,
   input  lane_mask_t          cmt_prd_we,
   input  bpu_upd_t [CW-1:0]   cmt_bpu_upd,
   // Load/store unit
   output logic                lsu_req_valid,
   input  logic                lsu_wb_valid,
   input  data_t               lsu_wb_dout,
   // Exception unit
   output logic                epu_req_valid,
   input  logic                epu_wb_valid,
   input  data_t               epu_wb_dout,
   input  logic                epu_wb_dout_sel,
   input  logic                exc_flush,
   input  pc_t                 exc_flush_tgt,
   input  logic                refetch,
   // To ROB and front end
   output logic                flush,
   output pc_t                 flush_tgt,
   output lane_mask_t          cmt_fire,
   output pop_size_t           cmt_pop_size,
   // Register file write
   output logic                prf_we,
   output prf_addr_t           prf_waddr,
   output data_t               prf_wdata,
   // To BPU
   output logic                bpu_wb,
   output logic                bpu_wb_is_bcc,
   output logic                bpu_wb_is_breg,
   output logic                bpu_wb_is_brel,
   output logic                bpu_wb_taken,
   output pc_t                 bpu_wb_pc,
   output pc_t                 bpu_wb_npc_act,
   output bpu_upd_t            bpu_wb_upd
);
   logic se_fls;
   logic pipe_req;
   logic lsu_req0;
   logic epu_req0;
   logic cmt_ce;

   cmt_lane_sel u_lane_sel
   (
      .cmt_valid     (cmt_valid),
      .cmt_lsu_opc   (cmt_lsu_opc),
      .cmt_epu_opc   (cmt_epu_opc),
      .cmt_exc       (cmt_exc),
      .cmt_fls       (cmt_fls),
      .cmt_is_bcc    (cmt_is_bcc),
      .cmt_is_brel   (cmt_is_brel),
      .cmt_is_breg   (cmt_is_breg),
      .se_fls        (se_fls),
      .flush         (flush),
      .cmt_ce        (cmt_ce),
      .pipe_req      (pipe_req),
      .lsu_req0      (lsu_req0),
      .epu_req0      (epu_req0),
      .cmt_fire      (cmt_fire),
      .cmt_pop_size  (cmt_pop_size)
   );

   cmt_fu_seq u_fu_seq
   (
      .clk             (clk),
      .rst_n           (rst_n),
      .pipe_req        (pipe_req),
      .lsu_req0        (lsu_req0),
      .epu_req0        (epu_req0),
      .flush           (flush),
      .lsu_wb_valid    (lsu_wb_valid),
      .lsu_wb_dout     (lsu_wb_dout),
      .epu_wb_valid    (epu_wb_valid),
      .epu_wb_dout     (epu_wb_dout),
      .epu_wb_dout_sel (epu_wb_dout_sel),
      .cmt_prd0        (cmt_prd[0]),       // Only lane 0 writes back
      .cmt_prd_we0     (cmt_prd_we[0]),
      .cmt_ce          (cmt_ce),
      .lsu_req_valid   (lsu_req_valid),
      .epu_req_valid   (epu_req_valid),
      .prf_we          (prf_we),
      .prf_waddr       (prf_waddr),
      .prf_wdata       (prf_wdata)
   );

   cmt_redirect u_redirect
   (
      .clk             (clk),
      .rst_n           (rst_n),
      .cmt_fire        (cmt_fire),
      .cmt_fls0        (cmt_fls[0]),
      .refetch         (refetch),
      .cmt_pc0         (cmt_pc[0]),
      .cmt_opera0      (cmt_opera[0]),
      .exc_flush       (exc_flush),
      .exc_flush_tgt   (exc_flush_tgt),
      .cmt_is_bcc0     (cmt_is_bcc[0]),
      .cmt_is_breg0    (cmt_is_breg[0]),
      .cmt_is_brel0    (cmt_is_brel[0]),
      .cmt_bpu_upd0    (cmt_bpu_upd[0]),
      .se_fls          (se_fls),
      .flush           (flush),
      .flush_tgt       (flush_tgt),
      .bpu_wb          (bpu_wb),
      .bpu_wb_is_bcc   (bpu_wb_is_bcc),
      .bpu_wb_is_breg  (bpu_wb_is_breg),
      .bpu_wb_is_brel  (bpu_wb_is_brel),
      .bpu_wb_taken    (bpu_wb_taken),
      .bpu_wb_pc       (bpu_wb_pc),
      .bpu_wb_npc_act  (bpu_wb_npc_act),
      .bpu_wb_upd      (bpu_wb_upd)
   );

endmodule

//--- verification/cmt_assert.sv
// Commit stage assertions
module cmt_assert
   import cmt_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        lsu_req_valid,
   input  logic        epu_req_valid,
   input  lane_mask_t  cmt_valid,
   input  lane_mask_t  cmt_fire,
   input  logic        prf_we,
   input  logic        lsu_wb_valid,
   input  logic        epu_wb_valid,
   input  logic        se_fls
);
   timeunit 1ns;
   timeprecision 1ps;

   a_one_req: assert property (@(posedge clk) disable iff (!rst_n)
      !(lsu_req_valid && epu_req_valid))
      else $error("both unit requests high in one cycle");

   a_fire_valid: assert property (@(posedge clk) disable iff (!rst_n)
      (cmt_fire & ~cmt_valid) == '0)
      else $error("fire on a lane that is not valid");

   a_we_done: assert property (@(posedge clk) disable iff (!rst_n)
      prf_we |-> (lsu_wb_valid || epu_wb_valid))
      else $error("register write without a done strobe");

   a_se_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      se_fls |=> !se_fls)
      else $error("speculative flush held for two cycles");

endmodule

bind cmt cmt_assert i_assert
(
   .clk           (clk),
   .rst_n         (rst_n),
   .lsu_req_valid (lsu_req_valid),
   .epu_req_valid (epu_req_valid),
   .cmt_valid     (cmt_valid),
   .cmt_fire      (cmt_fire),
   .prf_we        (prf_we),
   .lsu_wb_valid  (lsu_wb_valid),
   .epu_wb_valid  (epu_wb_valid),
   .se_fls        (se_fls)
);

//--- verification/tb_cmt.sv
// Commit stage testbench
module tb_cmt
   import cmt_pkg::*;
;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_MIX = 400;
   localparam int N_OPS = 60;
   localparam int LIMIT = 20 * (7 + N_MIX + N_OPS * 12);

   logic clk, rst_n;
   lane_mask_t cmt_valid, cmt_exc, cmt_fls, cmt_is_bcc, cmt_is_brel, cmt_is_breg, cmt_prd_we;
   lsu_opc_t [CW-1:0] cmt_lsu_opc;
   epu_opc_t [CW-1:0] cmt_epu_opc;
   pc_t [CW-1:0] cmt_pc;
   data_t [CW-1:0] cmt_opera;
   prf_addr_t [CW-1:0] cmt_prd;
   bpu_upd_t [CW-1:0] cmt_bpu_upd;
   logic lsu_wb_valid, epu_wb_valid, epu_wb_dout_sel, exc_flush, refetch;
   data_t lsu_wb_dout, epu_wb_dout;
   pc_t exc_flush_tgt;
   logic lsu_req_valid, epu_req_valid, flush, prf_we, bpu_wb;
   logic bpu_wb_is_bcc, bpu_wb_is_breg, bpu_wb_is_brel, bpu_wb_taken;
   pc_t flush_tgt, bpu_wb_pc, bpu_wb_npc_act;
   lane_mask_t cmt_fire;
   pop_size_t cmt_pop_size;
   prf_addr_t prf_waddr;
   data_t prf_wdata;
   bpu_upd_t bpu_wb_upd;
   int errors = 0;
   int cycles = 0;
   logic m_se, m_pend;                                    // Model of flush pulse and FU state
   pc_t m_tgt;

   cmt i_dut (.*);

   initial
      begin
         clk = 1'b0;
         forever #4 clk = ~clk;
      end

   // Expected fire vector from the mask chain rule
   function automatic lane_mask_t ref_commit(lane_mask_t valid, lsu_opc_t [CW-1:0] lopc,
      epu_opc_t [CW-1:0] eopc, lane_mask_t exc, lane_mask_t fls, lane_mask_t br,
      logic se, logic fl, logic done);
      lane_mask_t single, mask;
      logic ce;
      for (int i = 0; i < CW; i++)
         single[i] = (!se && (lopc[i] != '0 || eopc[i] != '0 || exc[i])) || fls[i] || br[i];
      ce = !(valid[0] && !se && (lopc[0] != '0 || eopc[0] != '0 || exc[0])) || done;
      mask[0] = ce && !fl;
      mask[1] = mask[0] && !single[0] && !single[1];
      for (int i = 2; i < CW; i++)
         mask[i] = mask[i-1] && !single[i];
      return valid & mask;
   endfunction

   task automatic check(string name, logic [31:0] exp, logic [31:0] act);
      if (exp !== act)
         begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            errors++;
         end
   endtask

   always
      begin : compare
         logic done, l0, e0, preq, e_fl, e_bpu;
         lane_mask_t e_fire;
         int cnt;
         @(negedge clk);
         #2;                                              // Inputs settled before the rising edge
         if (!rst_n)
            begin
               m_se = 1'b0;
               m_pend = 1'b0;
            end
         else
            begin
               done = lsu_wb_valid || epu_wb_valid;
               l0 = !m_se && cmt_lsu_opc[0] != '0;
               e0 = !m_se && (cmt_epu_opc[0] != '0 || cmt_exc[0]);
               preq = cmt_valid[0] && (l0 || e0);
               e_fl = m_se || exc_flush;
               e_fire = ref_commit(cmt_valid, cmt_lsu_opc, cmt_epu_opc, cmt_exc, cmt_fls,
                                   cmt_is_bcc | cmt_is_brel | cmt_is_breg, m_se, e_fl, done);
               cnt = 0;
               for (int i = 0; i < CW; i++)
                  cnt += int'(e_fire[i]);
               check("fire", 32'(e_fire), 32'(cmt_fire));
               check("pop_size", 32'(cnt), 32'(cmt_pop_size));
               check("flush", 32'(e_fl), 32'(flush));
               if (e_fl)
                  check("flush_tgt", 32'(m_se ? m_tgt : exc_flush_tgt), 32'(flush_tgt));
               check("lsu_req", 32'(!m_pend && preq && l0), 32'(lsu_req_valid));
               check("epu_req", 32'(!m_pend && preq && e0 && !l0), 32'(epu_req_valid));
               check("prf_we", 32'(done && !e_fl && cmt_prd_we[0]), 32'(prf_we));
               if (done && !e_fl && cmt_prd_we[0])
                  begin
                     check("prf_waddr", 32'(cmt_prd[0]), 32'(prf_waddr));
                     check("prf_wdata", epu_wb_dout_sel ? epu_wb_dout : lsu_wb_dout, prf_wdata);
                  end
               e_bpu = e_fire[0] && (cmt_is_bcc[0] || cmt_is_brel[0] || cmt_is_breg[0]);
               check("bpu_wb", 32'(e_bpu), 32'(bpu_wb));
               if (e_bpu)
                  begin
                     check("bpu_taken", 32'(cmt_bpu_upd[0][31] ^ cmt_fls[0]), 32'(bpu_wb_taken));
                     check("bpu_npc", 32'(cmt_fls[0] ? cmt_opera[0][29:0] : cmt_bpu_upd[0][29:0]),
                           32'(bpu_wb_npc_act));
                     check("bpu_pc", 32'(cmt_pc[0]), 32'(bpu_wb_pc));
                     check("bpu_flags", {29'd0, cmt_is_bcc[0], cmt_is_breg[0], cmt_is_brel[0]},
                           {29'd0, bpu_wb_is_bcc, bpu_wb_is_breg, bpu_wb_is_brel});
                     check("bpu_upd", cmt_bpu_upd[0], bpu_wb_upd);
                  end
               m_tgt = cmt_fls[0] ? cmt_opera[0][PC_W-1:0] : cmt_pc[0] + pc_t'(1);
               m_se = e_fire[0] && (cmt_fls[0] || refetch);
               if (!m_pend && preq)
                  m_pend = 1'b1;
               else if (m_pend && done)
                  m_pend = 1'b0;
            end
      end

   // Random lane mix; lane 0 never needs a unit
   task automatic drive_mix(logic quiet);
      int n;
      n = quiet ? 0 : $urandom_range(0, 4);
      cmt_valid = lane_mask_t'((32'd1 << n) - 32'd1);
      for (int i = 0; i < CW; i++)
         begin
            cmt_lsu_opc[i] = ($urandom_range(0, 5) == 0) ? lsu_opc_t'($urandom_range(1, 15)) : '0;
            cmt_epu_opc[i] = ($urandom_range(0, 7) == 0) ? epu_opc_t'($urandom_range(1, 63)) : '0;
            cmt_exc[i] = ($urandom_range(0, 15) == 0);
            cmt_fls[i] = ($urandom_range(0, 7) == 0);
            cmt_is_bcc[i] = ($urandom_range(0, 5) == 0);
            cmt_is_brel[i] = ($urandom_range(0, 9) == 0);
            cmt_is_breg[i] = ($urandom_range(0, 9) == 0);
            cmt_pc[i] = pc_t'($urandom);
            cmt_opera[i] = $urandom;
            cmt_prd[i] = prf_addr_t'($urandom);
            cmt_prd_we[i] = ($urandom_range(0, 1) == 1);
            cmt_bpu_upd[i] = $urandom;
         end
      cmt_lsu_opc[0] = '0;
      cmt_epu_opc[0] = '0;
      cmt_exc[0] = 1'b0;
      exc_flush = !quiet && ($urandom_range(0, 11) == 0);
      exc_flush_tgt = pc_t'($urandom);
   endtask

   // Lane-0 unit operation with the outside unit answering after 1 to 4 cycles
   task automatic unit_op();
      logic use_lsu;
      int lat;
      @(negedge clk);
      drive_mix(1'b1);                                    // Idle cycle lets any flush pass
      @(negedge clk);
      drive_mix(1'b0);
      use_lsu = ($urandom_range(0, 1) == 1);
      cmt_valid[0] = 1'b1;
      cmt_fls[0] = 1'b0;
      cmt_is_bcc[0] = 1'b0;
      cmt_is_brel[0] = 1'b0;
      cmt_is_breg[0] = 1'b0;
      exc_flush = 1'b0;
      if (use_lsu)
         cmt_lsu_opc[0] = lsu_opc_t'($urandom_range(1, 15));
      else if ($urandom_range(0, 3) == 0)
         cmt_exc[0] = 1'b1;
      else
         cmt_epu_opc[0] = epu_opc_t'($urandom_range(1, 63));
      #1;
      if (!(lsu_req_valid || epu_req_valid))
         begin
            $display("Lane-0 unit operation issued no request");
            errors++;
         end
      lat = $urandom_range(1, 4);
      repeat (lat) @(negedge clk);
      lsu_wb_dout = $urandom;
      epu_wb_dout = $urandom;
      if (use_lsu)
         lsu_wb_valid = 1'b1;
      else
         begin
            epu_wb_valid = 1'b1;
            epu_wb_dout_sel = ($urandom_range(0, 1) == 1);
            refetch = ($urandom_range(0, 1) == 1);
         end
      exc_flush = ($urandom_range(0, 3) == 0);            // Flush may cancel the writeback
      @(negedge clk);
      lsu_wb_valid = 1'b0;
      epu_wb_valid = 1'b0;
      epu_wb_dout_sel = 1'b0;
      refetch = 1'b0;
      drive_mix(1'b0);
   endtask

   initial
      begin
         void'($urandom(32'h48005529));
         rst_n = 1'b0;
         lsu_wb_valid = 1'b0;
         epu_wb_valid = 1'b0;
         epu_wb_dout_sel = 1'b0;
         lsu_wb_dout = '0;
         epu_wb_dout = '0;
         refetch = 1'b0;
         drive_mix(1'b1);
         repeat (3) @(posedge clk);
         @(negedge clk);
         rst_n = 1'b1;
         repeat (4) @(negedge clk);                       // Idle after reset
         for (int i = 0; i < N_MIX; i++)
            begin
               @(negedge clk);
               drive_mix(1'b0);
               if (i % 7 == 0)
                  unit_op();
            end
         @(negedge clk);
         drive_mix(1'b1);
         @(negedge clk);
         $display("Checks finished with %0d errors", errors);
         if (errors == 0)
            $display("TESTS PASSED");
         else
            $display("TESTS FAILED");
         $finish;
      end

   initial
      begin
         while (cycles < LIMIT)
            begin
               @(posedge clk);
               cycles++;
            end
         $display("Run did not finish within %0d cycles", LIMIT);
         $display("TESTS FAILED");
         $finish;
      end

endmodule

//--- tb.f
source/cmt_pkg.sv
source/cmt_lane_sel.sv
source/cmt_fu_seq.sv
source/cmt_redirect.sv
source/cmt.sv
verification/cmt_assert.sv
verification/tb_cmt.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_cmt
FILELIST  ?= tb.f

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
